// File: exec_cluster.f
rtl/exec_pkg.sv
rtl/exec_stage.sv
rtl/alu_unit.sv
rtl/branch_unit.sv
rtl/writeback_bypass.sv
rtl/exec_cluster.sv
sim/tb_clock.sv
sim/tb_exec_cluster.sv

// File: rtl/alu_unit.sv
`default_nettype none

module alu_unit
	import exec_pkg::*;
(
	input  wire logic    i_clk,
	input  wire logic    i_rst_n,
	input  wire logic    i_val,
	input  wire uop_t    i_uop,
	input  wire brmask_t i_brmask,
	input  wire brmask_t i_brkill,
	input  wire prd_t    i_prd,
	input  wire xlen_t   i_op1,
	input  wire xlen_t   i_op2,
	input  wire xlen_t   i_imm,
	output logic         o_val,
	output alu_res_t     o_res
);

	xlen_t                op_b;
	logic [SHAMT_W-1:0]   shamt;
	xlen_t                alu_data;
	alu_res_t             alu_res;

	assign op_b  = (i_uop == UOP_ADDI) ? i_imm : i_op2;
	assign shamt = i_op2[SHAMT_W-1:0];

	always_comb begin
		case (i_uop)
			UOP_ADD, UOP_ADDI: alu_data = i_op1 + op_b;
			UOP_SUB:           alu_data = i_op1 - op_b;
			UOP_AND:           alu_data = i_op1 & op_b;
			UOP_OR:            alu_data = i_op1 | op_b;
			UOP_XOR:           alu_data = i_op1 ^ op_b;
			UOP_SLT:           alu_data = xlen_t'($signed(i_op1) < $signed(op_b));
			UOP_SLL:           alu_data = i_op1 << shamt;
			UOP_SRL:           alu_data = i_op1 >> shamt;
			default:           alu_data = '0;
		endcase
	end

	assign alu_res = '{prd: i_prd, data: alu_data};

	exec_stage #(
		.T_RES(alu_res_t)
	) u_stage (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_val   (i_val & is_alu_uop(i_uop)),
		.i_res   (alu_res),
		.i_brmask(i_brmask),
		.i_brkill(i_brkill),
		.o_val   (o_val),
		.o_res   (o_res)
	);

endmodule

`default_nettype wire

// File: rtl/branch_unit.sv
`default_nettype none

module branch_unit
	import exec_pkg::*;
(
	input  wire logic    i_clk,
	input  wire logic    i_rst_n,
	input  wire logic    i_val,
	input  wire uop_t    i_uop,
	input  wire brmask_t i_brmask,
	input  wire brtag_t  i_brtag,
	input  wire prd_t    i_prd,
	input  wire xlen_t   i_op1,
	input  wire xlen_t   i_op2,
	input  wire xlen_t   i_imm,
	input  wire xlen_t   i_pc,
	output logic         o_val,
	output br_res_t      o_res,
	output brmask_t      o_brkill,
	output xlen_t        o_redirect_pc
);

	logic    br_val;
	logic    taken;
	logic    live;
	logic    mispredict;
	br_res_t br_res;

	assign br_val = i_val & is_br_uop(i_uop);

	always_comb begin
		case (i_uop)
			UOP_BEQ: taken = (i_op1 == i_op2);
			UOP_BNE: taken = (i_op1 != i_op2);
			UOP_BLT: taken = ($signed(i_op1) < $signed(i_op2));
			UOP_JAL: taken = 1'b1;
			default: taken = 1'b0;
		endcase
	end

	// predicted not-taken, so any taken branch redirects
	// a branch already killed by an older one stays quiet
	assign live       = br_val & ~|(i_brmask & o_brkill);
	assign mispredict = live & taken;

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			o_brkill <= '0;
		end else begin
			o_brkill <= mispredict ? (brmask_t'(1) << i_brtag) : '0;
		end
	end

	always_ff @(posedge i_clk) begin
		if (mispredict) begin
			o_redirect_pc <= i_pc + i_imm;
		end
	end

	// link value, written only by jal
	assign br_res = '{prd: i_prd, data: i_pc + xlen_t'(4), we: (i_uop == UOP_JAL)};

	exec_stage #(
		.T_RES(br_res_t)
	) u_stage (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_val   (br_val),
		.i_res   (br_res),
		.i_brmask(i_brmask),
		.i_brkill(o_brkill),
		.o_val   (o_val),
		.o_res   (o_res)
	);

endmodule

`default_nettype wire

// File: rtl/exec_cluster.sv
`default_nettype none

module exec_cluster
	import exec_pkg::*;
(
	input  wire logic    i_clk,
	input  wire logic    i_rst_n,
	input  wire logic    i_val,
	input  wire uop_t    i_uop,
	input  wire brmask_t i_brmask,
	input  wire brtag_t  i_brtag,
	input  wire prd_t    i_prd,
	input  wire prd_t    i_prs1,
	input  wire prd_t    i_prs2,
	input  wire xlen_t   i_op1,
	input  wire xlen_t   i_op2,
	input  wire xlen_t   i_imm,
	input  wire xlen_t   i_pc,
	output logic         o_wb_we,
	output prd_t         o_wb_prd,
	output xlen_t        o_wb_data,
	output brmask_t      o_brkill,
	output xlen_t        o_redirect_pc
);

	logic     alu_val;
	alu_res_t alu_res;
	logic     br_val;
	br_res_t  br_res;
	xlen_t    fwd_op1;
	xlen_t    fwd_op2;
	brmask_t  brkill;

	assign o_brkill = brkill;

	// writeback merge and operand forwarding
	writeback_bypass u_writeback_bypass (
		.i_alu_val(alu_val),
		.i_alu_res(alu_res),
		.i_br_val (br_val),
		.i_br_res (br_res),
		.i_prs1   (i_prs1),
		.i_prs2   (i_prs2),
		.i_op1    (i_op1),
		.i_op2    (i_op2),
		.o_wb_we  (o_wb_we),
		.o_wb_prd (o_wb_prd),
		.o_wb_data(o_wb_data),
		.o_fwd_op1(fwd_op1),
		.o_fwd_op2(fwd_op2)
	);

	alu_unit u_alu_unit (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_val   (i_val),
		.i_uop   (i_uop),
		.i_brmask(i_brmask),
		.i_brkill(brkill),
		.i_prd   (i_prd),
		.i_op1   (fwd_op1),
		.i_op2   (fwd_op2),
		.i_imm   (i_imm),
		.o_val   (alu_val),
		.o_res   (alu_res)
	);

	// also owns the kill vector
	branch_unit u_branch_unit (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_val        (i_val),
		.i_uop        (i_uop),
		.i_brmask     (i_brmask),
		.i_brtag      (i_brtag),
		.i_prd        (i_prd),
		.i_op1        (fwd_op1),
		.i_op2        (fwd_op2),
		.i_imm        (i_imm),
		.i_pc         (i_pc),
		.o_val        (br_val),
		.o_res        (br_res),
		.o_brkill     (brkill),
		.o_redirect_pc(o_redirect_pc)
	);

endmodule

`default_nettype wire

// File: rtl/exec_pkg.sv
`default_nettype none

package exec_pkg;

	localparam int XLEN      = 32;
	localparam int WIDTH_PRD = 7;
	localparam int WIDTH_BRM = 3;
	localparam int N_BRTAG   = 1 << WIDTH_BRM;
	// shift amount comes from the low bits of operand 2
	localparam int SHAMT_W   = 5;

	typedef logic [XLEN-1:0]      xlen_t;
	typedef logic [WIDTH_PRD-1:0] prd_t;
	typedef logic [WIDTH_BRM-1:0] brtag_t;
	typedef logic [N_BRTAG-1:0]   brmask_t;

	// alu class first, branch class in the top quarter
	typedef enum logic [3:0] {
		UOP_ADD  = 4'h0,
		UOP_SUB  = 4'h1,
		UOP_AND  = 4'h2,
		UOP_OR   = 4'h3,
		UOP_XOR  = 4'h4,
		UOP_SLT  = 4'h5,
		UOP_SLL  = 4'h6,
		UOP_SRL  = 4'h7,
		UOP_ADDI = 4'h8,
		UOP_BEQ  = 4'hc,
		UOP_BNE  = 4'hd,
		UOP_BLT  = 4'he,
		UOP_JAL  = 4'hf
	} uop_t;

	typedef struct packed {
		prd_t  prd;
		xlen_t data;
	} alu_res_t;

	// we is set only for link writes
	typedef struct packed {
		prd_t  prd;
		xlen_t data;
		logic  we;
	} br_res_t;

	function automatic logic is_alu_uop(uop_t uop);
		return uop inside {UOP_ADD, UOP_SUB, UOP_AND, UOP_OR, UOP_XOR,
		                   UOP_SLT, UOP_SLL, UOP_SRL, UOP_ADDI};
	endfunction

	function automatic logic is_br_uop(uop_t uop);
		return uop inside {UOP_BEQ, UOP_BNE, UOP_BLT, UOP_JAL};
	endfunction

endpackage

`default_nettype wire

// File: rtl/exec_stage.sv
`default_nettype none

module exec_stage
	import exec_pkg::*;
#(
	parameter type T_RES = alu_res_t
) (
	input  wire logic    i_clk,
	input  wire logic    i_rst_n,
	input  wire logic    i_val,
	input  wire T_RES    i_res,
	input  wire brmask_t i_brmask,
	input  wire brmask_t i_brkill,
	output logic         o_val,
	output T_RES         o_res
);

	logic killed;

	// op depends on a branch resolved wrong this cycle
	assign killed = |(i_brmask & i_brkill);

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			o_val <= 1'b0;
		end else begin
			o_val <= i_val & ~killed;
		end
	end

	// payload only moves with a valid op
	always_ff @(posedge i_clk) begin
		if (i_val) begin
			o_res <= i_res;
		end
	end

endmodule

`default_nettype wire

// File: rtl/writeback_bypass.sv
`default_nettype none

module writeback_bypass
	import exec_pkg::*;
(
	input  wire logic     i_alu_val,
	input  wire alu_res_t i_alu_res,
	input  wire logic     i_br_val,
	input  wire br_res_t  i_br_res,
	input  wire prd_t     i_prs1,
	input  wire prd_t     i_prs2,
	input  wire xlen_t    i_op1,
	input  wire xlen_t    i_op2,
	output logic          o_wb_we,
	output prd_t          o_wb_prd,
	output xlen_t         o_wb_data,
	output xlen_t         o_fwd_op1,
	output xlen_t         o_fwd_op2
);

	logic  req;
	prd_t  sel_prd;
	xlen_t sel_data;

	// one issue per cycle, so at most one pipe is valid
	always_comb begin
		if (i_br_val) begin
			req      = i_br_res.we;
			sel_prd  = i_br_res.prd;
			sel_data = i_br_res.data;
		end else begin
			req      = i_alu_val;
			sel_prd  = i_alu_res.prd;
			sel_data = i_alu_res.data;
		end
	end

	// p0 is the hardwired zero register
	assign o_wb_we   = req & (sel_prd != '0);
	assign o_wb_prd  = sel_prd;
	assign o_wb_data = sel_data;

	// forward the writeback to the op issuing now
	assign o_fwd_op1 = (o_wb_we && (i_prs1 == o_wb_prd)) ? o_wb_data : i_op1;
	assign o_fwd_op2 = (o_wb_we && (i_prs2 == o_wb_prd)) ? o_wb_data : i_op2;

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build the exec cluster testbench with verilator, run it, look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module tb_exec_cluster \
	-f exec_cluster.f -o sim_exec_cluster &&
./obj_dir/sim_exec_cluster | tee /dev/stderr | grep -q "ALL CHECKS PASSED" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: sim/tb_clock.sv
`default_nettype none

module tb_clock (
	output logic o_clk,
	output logic o_rst_n
);
	timeunit 1ns;
	timeprecision 100ps;

	// 100 ns period
	initial begin
		o_clk = 1'b0;
		forever #50 o_clk = ~o_clk;
	end

	// held over ten rising edges, released on a falling edge
	initial begin
		o_rst_n = 1'b0;
		repeat (10) @(posedge o_clk);
		@(negedge o_clk);
		o_rst_n = 1'b1;
	end

endmodule

`default_nettype wire

// File: sim/tb_exec_cluster.sv
`default_nettype none

module tb_exec_cluster
	import exec_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	typedef struct {
		logic       val;
		uop_t       uop;
		brmask_t    mask;
		brtag_t     tag;
		prd_t       prd;
		prd_t       prs1;
		prd_t       prs2;
		logic [1:0] rnd;
		xlen_t      op1;
		xlen_t      op2;
		xlen_t      imm;
		xlen_t      pc;
		logic       exp_we;
		logic       exp_kill;
		logic       by_model;
	} row_t;

	logic    clk;
	logic    rst_n;
	logic    val;
	uop_t    uop;
	brmask_t brmask;
	brtag_t  brtag;
	prd_t    prd;
	prd_t    prs1;
	prd_t    prs2;
	xlen_t   op1;
	xlen_t   op2;
	xlen_t   imm;
	xlen_t   pc;
	logic    wb_we;
	prd_t    wb_prd;
	xlen_t   wb_data;
	brmask_t brkill;
	xlen_t   redirect_pc;

	// what the ports should show after the last issue
	logic        m_we = 1'b0;
	prd_t        m_prd = '0;
	xlen_t       m_data = '0;
	brmask_t     m_kill = '0;
	xlen_t       m_redir = '0;
	logic        chk_we = 1'b0;
	brmask_t     chk_kill = '0;
	row_t        rows[$];
	logic        table_built = 1'b0;
	logic [31:0] lfsr = 32'd77;

	tb_clock u_tb_clock (
		.o_clk  (clk),
		.o_rst_n(rst_n)
	);

	exec_cluster u_exec_cluster (
		.i_clk        (clk),
		.i_rst_n      (rst_n),
		.i_val        (val),
		.i_uop        (uop),
		.i_brmask     (brmask),
		.i_brtag      (brtag),
		.i_prd        (prd),
		.i_prs1       (prs1),
		.i_prs2       (prs2),
		.i_op1        (op1),
		.i_op2        (op2),
		.i_imm        (imm),
		.i_pc         (pc),
		.o_wb_we      (wb_we),
		.o_wb_prd     (wb_prd),
		.o_wb_data    (wb_data),
		.o_brkill     (brkill),
		.o_redirect_pc(redirect_pc)
	);

	// galois form with taps of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// one lfsr step per bit
	task automatic draw_word(output xlen_t w);
		int k;
		w = '0;
		for (k = 0; k < XLEN; k++) begin
			w = {lfsr[0], w[XLEN-1:1]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	function automatic xlen_t alu_ref(input uop_t op, input xlen_t a, input xlen_t b,
			input xlen_t k);
		case (op)
			UOP_ADD:  return a + b;
			UOP_SUB:  return a - b;
			UOP_AND:  return a & b;
			UOP_OR:   return a | b;
			UOP_XOR:  return a ^ b;
			UOP_SLT:  return {31'd0, $signed(a) < $signed(b)};
			UOP_SLL:  return a << b[4:0];
			UOP_SRL:  return a >> b[4:0];
			UOP_ADDI: return a + k;
			default:  return '0;
		endcase
	endfunction

	function automatic logic br_taken_ref(input uop_t op, input xlen_t a, input xlen_t b);
		case (op)
			UOP_BEQ: return a == b;
			UOP_BNE: return a != b;
			UOP_BLT: return $signed(a) < $signed(b);
			default: return op == UOP_JAL;
		endcase
	endfunction

	task automatic stop_run();
		$display("CHECKS FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic report_mismatch(input string name, input xlen_t e, input xlen_t a);
		$display("[ERROR] %0d ns %s expected %h actual %h", $time, name, e, a);
		stop_run();
	endtask

	task automatic check_wb(input prd_t e_prd, input xlen_t e_data, input logic e_we);
		if (wb_we !== e_we) begin
			report_mismatch("o_wb_we", xlen_t'(e_we), xlen_t'(wb_we));
		end else if (e_we && wb_prd !== e_prd) begin
			report_mismatch("o_wb_prd", xlen_t'(e_prd), xlen_t'(wb_prd));
		end else if (e_we && wb_data !== e_data) begin
			report_mismatch("o_wb_data", e_data, wb_data);
		end
	endtask

	task automatic check_kill(input brmask_t e_kill, input xlen_t e_pc);
		if (brkill !== e_kill) begin
			report_mismatch("o_brkill", xlen_t'(e_kill), xlen_t'(brkill));
		end else if (e_kill != '0 && redirect_pc !== e_pc) begin
			report_mismatch("o_redirect_pc", e_pc, redirect_pc);
		end
	endtask

	task automatic add_row(input int v, input uop_t u, input int mask, input int tag,
			input int p, input int s1, input int s2, input int rnd, input xlen_t a,
			input xlen_t b, input xlen_t k, input xlen_t pcv, input int we,
			input int kill, input int mdl);
		row_t r;
		r.val      = (v != 0);
		r.uop      = u;
		r.mask     = brmask_t'(mask);
		r.tag      = brtag_t'(tag);
		r.prd      = prd_t'(p);
		r.prs1     = prd_t'(s1);
		r.prs2     = prd_t'(s2);
		r.rnd      = 2'(rnd);
		r.op1      = a;
		r.op2      = b;
		r.imm      = k;
		r.pc       = pcv;
		r.exp_we   = (we != 0);
		r.exp_kill = (kill != 0);
		r.by_model = (mdl != 0);
		rows.push_back(r);
	endtask

	// drive one row and advance the reference by one issue
	task automatic apply_row(input row_t r);
		xlen_t a;
		xlen_t b;
		xlen_t fa;
		xlen_t fb;
		logic  killed;
		a = r.op1;
		b = r.op2;
		if (r.rnd[0]) begin
			draw_word(a);
		end
		if (r.rnd[1]) begin
			draw_word(b);
		end
		val    = r.val;
		uop    = r.uop;
		brmask = r.mask;
		brtag  = r.tag;
		prd    = r.prd;
		prs1   = r.prs1;
		prs2   = r.prs2;
		op1    = a;
		op2    = b;
		imm    = r.imm;
		pc     = r.pc;
		// writeback on the port now replaces a matching source
		fa     = (m_we && r.prs1 == m_prd) ? m_data : a;
		fb     = (m_we && r.prs2 == m_prd) ? m_data : b;
		killed = |(r.mask & m_kill);
		m_we   = 1'b0;
		m_kill = '0;
		if (r.val && !killed && r.uop inside {UOP_ADD, UOP_SUB, UOP_AND, UOP_OR,
				UOP_XOR, UOP_SLT, UOP_SLL, UOP_SRL, UOP_ADDI}) begin
			m_we   = (r.prd != '0);
			m_prd  = r.prd;
			m_data = alu_ref(r.uop, fa, fb, r.imm);
		end else if (r.val && !killed) begin
			// predicted not-taken
			if (br_taken_ref(r.uop, fa, fb)) begin
				m_kill  = brmask_t'(1) << r.tag;
				m_redir = r.pc + r.imm;
			end
			m_we   = (r.uop == UOP_JAL) && (r.prd != '0);
			m_prd  = r.prd;
			m_data = r.pc + 32'd4;
		end
		chk_we   = r.by_model ? m_we : r.exp_we;
		chk_kill = r.by_model ? m_kill : (r.exp_kill ? brmask_t'(1) << r.tag : '0);
	endtask

	// val uop mask tag prd prs1 prs2 rnd op1 op2 imm pc | we kill model
	task automatic build_table();
		add_row(0, UOP_ADD, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
		add_row(0, UOP_ADD, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
		add_row(1, UOP_ADD, 0, 0, 1, 0, 0, 3, 0, 0, 0, 0, 1, 0, 0);
		add_row(1, UOP_SUB, 0, 0, 2, 0, 0, 3, 0, 0, 0, 0, 1, 0, 0);
		add_row(1, UOP_AND, 0, 0, 3, 0, 0, 3, 0, 0, 0, 0, 1, 0, 0);
		add_row(1, UOP_OR, 0, 0, 4, 0, 0, 3, 0, 0, 0, 0, 1, 0, 0);
		add_row(1, UOP_XOR, 0, 0, 5, 0, 0, 3, 0, 0, 0, 0, 1, 0, 0);
		add_row(1, UOP_SLT, 0, 0, 6, 0, 0, 3, 0, 0, 0, 0, 1, 0, 0);
		add_row(1, UOP_SLL, 0, 0, 7, 0, 0, 3, 0, 0, 0, 0, 1, 0, 0);
		add_row(1, UOP_SRL, 0, 0, 8, 0, 0, 3, 0, 0, 0, 0, 1, 0, 0);
		add_row(1, UOP_ADDI, 0, 0, 9, 0, 0, 1, 0, 0, 'h7ff, 0, 1, 0, 0);
		add_row(1, UOP_ADD, 0, 0, 0, 0, 0, 3, 0, 0, 0, 0, 0, 0, 0);
		// chain through forwarded results
		add_row(1, UOP_ADD, 0, 0, 10, 0, 0, 3, 0, 0, 0, 0, 1, 0, 0);
		add_row(1, UOP_SUB, 0, 0, 11, 10, 0, 2, 0, 0, 0, 0, 1, 0, 0);
		add_row(1, UOP_SLT, 0, 0, 12, 11, 11, 0, 5, 9, 0, 0, 1, 0, 0);
		add_row(1, UOP_ADDI, 0, 0, 40, 0, 0, 0, 3, 0, 4, 0, 1, 0, 0);
		add_row(1, UOP_BEQ, 0, 3, 0, 40, 0, 0, 0, 7, 'h20, 'h80, 0, 1, 0);
		add_row(1, UOP_BEQ, 0, 1, 0, 0, 0, 0, 5, 6, 'h20, 'hc0, 0, 0, 0);
		// squash and survive right after a kill
		add_row(1, UOP_BNE, 0, 2, 0, 0, 0, 0, 5, 6, 'h40, 'h100, 0, 1, 0);
		add_row(1, UOP_ADD, 'h04, 0, 20, 0, 0, 3, 0, 0, 0, 0, 0, 0, 0);
		add_row(1, UOP_BLT, 0, 5, 0, 0, 0, 0, -1, 1, -16, 'h140, 0, 1, 0);
		add_row(1, UOP_ADD, 'h01, 0, 21, 0, 0, 3, 0, 0, 0, 0, 1, 0, 0);
		add_row(1, UOP_JAL, 0, 7, 30, 0, 0, 0, 0, 0, 'h80, 'h200, 1, 1, 0);
		add_row(1, UOP_ADD, 0, 0, 31, 0, 30, 1, 0, 0, 0, 0, 1, 0, 0);
		add_row(1, UOP_JAL, 0, 4, 0, 0, 0, 0, 0, 0, 'h10, 'h300, 0, 1, 0);
		add_row(1, UOP_JAL, 'h10, 5, 32, 0, 0, 0, 0, 0, 'h10, 'h340, 0, 0, 0);
		add_row(1, UOP_BLT, 0, 2, 0, 0, 0, 3, 0, 0, 'h40, 'h400, 0, 0, 1);
		add_row(1, UOP_BNE, 0, 6, 0, 0, 0, 3, 0, 0, 'h40, 'h440, 0, 0, 1);
		add_row(0, UOP_ADD, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
	endtask

	initial begin
		int i;
		val    = 1'b0;
		uop    = UOP_ADD;
		brmask = '0;
		brtag  = '0;
		prd    = '0;
		prs1   = '0;
		prs2   = '0;
		op1    = '0;
		op2    = '0;
		imm    = '0;
		pc     = '0;
		build_table();
		table_built = 1'b1;
		wait (rst_n === 1'b1);
		check_wb(m_prd, m_data, chk_we);
		check_kill(chk_kill, m_redir);
		for (i = 0; i < rows.size(); i++) begin
			apply_row(rows[i]);
			@(negedge clk);
			check_wb(m_prd, m_data, chk_we);
			check_kill(chk_kill, m_redir);
		end
		$display("ALL CHECKS PASSED");
		$finish;
	end

	// reset plus one cycle per row plus slack
	initial begin
		wait (table_built);
		#((10 + rows.size() + 20) * 100);
		$display("timeout: the table did not finish in the expected number of cycles");
		stop_run();
	end

endmodule

`default_nettype wire
